/* hw/lc4_defines.svh */
/*
 * word and register-file sizes, reset fetch address, retire stall codes
 */
`ifndef LC4_DEFINES_SVH
`define LC4_DEFINES_SVH

// data and instruction width
`define LC4_WORD_W 16
// register file size and select width
`define LC4_REG_N 8
`define LC4_RSEL_W 3

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// stall codes seen on the retire record
`define LC4_STALL_NONE 2'd0
`define LC4_STALL_BRANCH 2'd2

`endif

/* hw/lc4_pkg.sv */
/*
 * opcode, alu-op and stall enums, pipeline records, bubble constant,
 * nzp helper
 */
`include "lc4_defines.svh"

package lc4_pkg;

    typedef enum logic [3:0] {
        OP_BR      = 4'b0000,
        OP_ARITH   = 4'b0001,
        OP_LOGIC   = 4'b0101,
        OP_CONST   = 4'b1001,
        OP_JMP     = 4'b1100,
        OP_HICONST = 4'b1101
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_NOT, ALU_OR, ALU_XOR,
        ALU_PASS_CONST, ALU_HICONST, ALU_PC_TARGET, ALU_NONE
    } alu_op_e;

    // codes 1 and 3 belong to hazards this core never has
    typedef enum logic [1:0] {
        STALL_NONE   = `LC4_STALL_NONE,
        STALL_BRANCH = `LC4_STALL_BRANCH
    } stall_e;

    // decoded control for one instruction
    typedef struct packed {
        logic [`LC4_RSEL_W-1:0] rs_sel;
        logic [`LC4_RSEL_W-1:0] rt_sel;
        logic [`LC4_RSEL_W-1:0] wsel;
        logic                   rs_re;
        logic                   rt_re;
        logic                   reg_we;
        logic                   nzp_we;
        logic                   is_branch;
        logic                   is_control;
        alu_op_e                alu_op;
        logic [`LC4_WORD_W-1:0] insn;
    } decode_t;

    // record passed from stage register to stage register
    typedef struct packed {
        decode_t                dec;
        logic [`LC4_WORD_W-1:0] pc;
        stall_e                 stall;
    } stage_t;

    // register write that also feeds the bypass
    typedef struct packed {
        logic                   we;
        logic [`LC4_RSEL_W-1:0] wsel;
        logic [`LC4_WORD_W-1:0] data;
    } wb_t;

    // what leaves the W stage each cycle
    typedef struct packed {
        logic [`LC4_WORD_W-1:0] pc;
        logic [`LC4_WORD_W-1:0] insn;
        stall_e                 stall;
        logic                   reg_we;
        logic [`LC4_RSEL_W-1:0] wsel;
        logic [`LC4_WORD_W-1:0] data;
        logic                   nzp_we;
        logic [2:0]             nzp;
    } retire_t;

    // insn 0 decodes as a never-taken BR, so a bubble has no side effects
    localparam stage_t STAGE_BUBBLE = '{dec: '0, pc: '0, stall: STALL_BRANCH};

    // one-hot n/z/p sign class of a result
    function automatic logic [2:0] nzp_of(input logic [`LC4_WORD_W-1:0] v);
        if ($signed(v) > 0) begin
            return 3'b001;
        end else if (v == '0) begin
            return 3'b010;
        end
        return 3'b100;
    endfunction

endpackage

/* hw/lc4_decode.sv */
/*
 * instruction decoder from 16-bit insn to decode record
 */
`timescale 1ns/1ps
`include "lc4_defines.svh"

module lc4_decode (
    input  logic [`LC4_WORD_W-1:0] i_insn,
    output lc4_pkg::decode_t       o_dec
);

    always_comb begin
        // default is an instruction that reads and writes nothing
        o_dec        = '0;
        o_dec.insn   = i_insn;
        o_dec.alu_op = lc4_pkg::ALU_NONE;
        o_dec.rs_sel = i_insn[8:6];
        o_dec.rt_sel = i_insn[2:0];
        o_dec.wsel   = i_insn[11:9];

        case (i_insn[15:12])
            lc4_pkg::OP_BR: begin
                // nzp field 000 is a nop
                o_dec.is_branch = |i_insn[11:9];
                o_dec.alu_op    = lc4_pkg::ALU_PC_TARGET;
            end
            lc4_pkg::OP_ARITH: begin
                // ADD, SUB and the imm form write rd while MUL and DIV stay nops
                if (i_insn[5] || !i_insn[3]) begin
                    o_dec.alu_op = (!i_insn[5] && i_insn[4]) ? lc4_pkg::ALU_SUB
                                                             : lc4_pkg::ALU_ADD;
                    o_dec.rs_re  = 1'b1;
                    o_dec.rt_re  = !i_insn[5];
                    o_dec.reg_we = 1'b1;
                    o_dec.nzp_we = 1'b1;
                end
            end
            lc4_pkg::OP_LOGIC: begin
                case ({i_insn[5], i_insn[4:3]})
                    3'b001:  o_dec.alu_op = lc4_pkg::ALU_NOT;
                    3'b010:  o_dec.alu_op = lc4_pkg::ALU_OR;
                    3'b011:  o_dec.alu_op = lc4_pkg::ALU_XOR;
                    default: o_dec.alu_op = lc4_pkg::ALU_AND;
                endcase
                o_dec.rs_re  = 1'b1;
                // NOT and the imm form have no second register
                o_dec.rt_re  = !i_insn[5] && (i_insn[4:3] != 2'b01);
                o_dec.reg_we = 1'b1;
                o_dec.nzp_we = 1'b1;
            end
            lc4_pkg::OP_CONST: begin
                o_dec.alu_op = lc4_pkg::ALU_PASS_CONST;
                o_dec.reg_we = 1'b1;
                o_dec.nzp_we = 1'b1;
            end
            lc4_pkg::OP_HICONST: begin
                // keeps the low byte of rd, so rd is also a source
                o_dec.rs_sel = i_insn[11:9];
                o_dec.rs_re  = 1'b1;
                o_dec.alu_op = lc4_pkg::ALU_HICONST;
                o_dec.reg_we = 1'b1;
                o_dec.nzp_we = 1'b1;
            end
            lc4_pkg::OP_JMP: begin
                // JMPR is not supported and decodes as a nop
                if (i_insn[11]) begin
                    o_dec.is_control = 1'b1;
                    o_dec.alu_op     = lc4_pkg::ALU_PC_TARGET;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* hw/lc4_regfile.sv */
/*
 * eight-entry register file, two reads, one write with write-through
 */
`timescale 1ns/1ps
`include "lc4_defines.svh"

module lc4_regfile (
    input  logic                   gwe,
    input  logic                   i_arst_n,
    input  logic [`LC4_RSEL_W-1:0] i_rs_sel,
    input  logic [`LC4_RSEL_W-1:0] i_rt_sel,
    input  lc4_pkg::wb_t           i_wb,
    output logic [`LC4_WORD_W-1:0] o_rs_data,
    output logic [`LC4_WORD_W-1:0] o_rt_data
);

    logic [`LC4_WORD_W-1:0] regs_q [`LC4_REG_N];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `LC4_REG_N; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_wb.we) begin
            regs_q[i_wb.wsel] <= i_wb.data;
        end
    end

    // a W-stage write shows up on the D-stage read in the same cycle
    assign o_rs_data = (i_wb.we && i_wb.wsel == i_rs_sel) ? i_wb.data : regs_q[i_rs_sel];
    assign o_rt_data = (i_wb.we && i_wb.wsel == i_rt_sel) ? i_wb.data : regs_q[i_rt_sel];

endmodule

/* hw/lc4_execute.sv */
/*
 * X stage with MX/WX bypass, ALU, NZP register and branch and jump resolution
 */
`timescale 1ns/1ps
`include "lc4_defines.svh"

module lc4_execute (
    input  logic                   gwe,
    input  logic                   i_arst_n,
    input  lc4_pkg::stage_t        i_x,
    input  logic [`LC4_WORD_W-1:0] i_rs_data,
    input  logic [`LC4_WORD_W-1:0] i_rt_data,
    input  lc4_pkg::wb_t           i_m_wb,
    input  lc4_pkg::wb_t           i_w_wb,
    output logic [`LC4_WORD_W-1:0] o_result,
    output logic                   o_redirect,
    output logic [`LC4_WORD_W-1:0] o_target
);

    logic [`LC4_WORD_W-1:0] rs_val;
    logic [`LC4_WORD_W-1:0] rt_val;
    logic [`LC4_WORD_W-1:0] op_b;
    logic [`LC4_WORD_W-1:0] imm5;
    logic [`LC4_WORD_W-1:0] imm9;
    logic [`LC4_WORD_W-1:0] imm11;
    logic [`LC4_WORD_W-1:0] pc_inc;
    logic [2:0]             nzp_q;

    // M stage wins over W, regfile value last
    function automatic logic [`LC4_WORD_W-1:0] bypass(
        input logic [`LC4_RSEL_W-1:0] sel,
        input logic                   re,
        input logic [`LC4_WORD_W-1:0] rf_data
    );
        if (re && i_m_wb.we && i_m_wb.wsel == sel) begin
            return i_m_wb.data;
        end else if (re && i_w_wb.we && i_w_wb.wsel == sel) begin
            return i_w_wb.data;
        end
        return rf_data;
    endfunction

    assign rs_val = bypass(i_x.dec.rs_sel, i_x.dec.rs_re, i_rs_data);
    assign rt_val = bypass(i_x.dec.rt_sel, i_x.dec.rt_re, i_rt_data);

    // sign-extended immediates straight from the insn
    assign imm5  = {{11{i_x.dec.insn[4]}}, i_x.dec.insn[4:0]};
    assign imm9  = {{7{i_x.dec.insn[8]}}, i_x.dec.insn[8:0]};
    assign imm11 = {{5{i_x.dec.insn[10]}}, i_x.dec.insn[10:0]};

    // imm forms of ADD/AND are the ones without rt
    assign op_b = i_x.dec.rt_re ? rt_val : imm5;

    // JMP carries an 11-bit offset, BR a 9-bit one
    assign pc_inc   = i_x.pc + 16'd1;
    assign o_target = pc_inc + (i_x.dec.is_control ? imm11 : imm9);

    always_comb begin
        case (i_x.dec.alu_op)
            lc4_pkg::ALU_ADD:        o_result = rs_val + op_b;
            lc4_pkg::ALU_SUB:        o_result = rs_val - op_b;
            lc4_pkg::ALU_AND:        o_result = rs_val & op_b;
            lc4_pkg::ALU_NOT:        o_result = ~rs_val;
            lc4_pkg::ALU_OR:         o_result = rs_val | op_b;
            lc4_pkg::ALU_XOR:        o_result = rs_val ^ op_b;
            lc4_pkg::ALU_PASS_CONST: o_result = imm9;
            lc4_pkg::ALU_HICONST:    o_result = {i_x.dec.insn[7:0], rs_val[7:0]};
            lc4_pkg::ALU_PC_TARGET:  o_result = o_target;
            default:                 o_result = '0;
        endcase
    end

    // written at the end of the X cycle, so the next insn in X sees it
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            nzp_q <= 3'b010;
        end else if (i_x.dec.nzp_we) begin
            nzp_q <= lc4_pkg::nzp_of(o_result);
        end
    end

    // taken when any requested condition bit is set
    assign o_redirect = i_x.dec.is_control ||
                        (i_x.dec.is_branch && |(i_x.dec.insn[11:9] & nzp_q));

endmodule

/* hw/lc4_result.sv */
/*
 * M and W stage registers, writeback buses, retire record
 */
`timescale 1ns/1ps
`include "lc4_defines.svh"

module lc4_result (
    input  logic                   gwe,
    input  logic                   i_arst_n,
    input  lc4_pkg::stage_t        i_x,
    input  logic [`LC4_WORD_W-1:0] i_result,
    input  logic                   i_flush_x,
    output lc4_pkg::wb_t           o_m_wb,
    output lc4_pkg::wb_t           o_w_wb,
    output lc4_pkg::retire_t       o_retire
);

    lc4_pkg::stage_t        m_q;
    lc4_pkg::stage_t        w_q;
    logic [`LC4_WORD_W-1:0] m_res_q;
    logic [`LC4_WORD_W-1:0] w_res_q;
    logic [2:0]             m_nzp_q;
    logic [2:0]             w_nzp_q;

    // stage records come out of reset as bubbles
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            m_q <= lc4_pkg::STAGE_BUBBLE;
            w_q <= lc4_pkg::STAGE_BUBBLE;
        end else begin
            // X slot behind a redirect never enters M as a real insn
            m_q <= i_flush_x ? lc4_pkg::STAGE_BUBBLE : i_x;
            w_q <= m_q;
        end
    end

    // result and its nzp bits are captured on the way into M
    always_ff @(posedge gwe) begin
        m_res_q <= i_result;
        m_nzp_q <= lc4_pkg::nzp_of(i_result);
        w_res_q <= m_res_q;
        w_nzp_q <= m_nzp_q;
    end

    assign o_m_wb = '{we: m_q.dec.reg_we, wsel: m_q.dec.wsel, data: m_res_q};
    assign o_w_wb = '{we: w_q.dec.reg_we, wsel: w_q.dec.wsel, data: w_res_q};

    always_comb begin
        o_retire.pc     = w_q.pc;
        o_retire.insn   = w_q.dec.insn;
        o_retire.stall  = w_q.stall;
        o_retire.reg_we = w_q.dec.reg_we;
        o_retire.wsel   = w_q.dec.wsel;
        o_retire.data   = w_res_q;
        o_retire.nzp_we = w_q.dec.nzp_we;
        o_retire.nzp    = w_nzp_q;
    end

endmodule

/* hw/lc4_core.sv */
/*
 * five-stage LC4 core top with fetch PC, D and X stage registers, redirect
 * flush and the decode/regfile/execute/result instances
 */
`timescale 1ns/1ps
`include "lc4_defines.svh"

module lc4_core (
    input  logic                   gwe,
    input  logic                   i_arst_n,
    input  logic [`LC4_WORD_W-1:0] i_cur_insn,
    output logic [`LC4_WORD_W-1:0] o_cur_pc,
    output lc4_pkg::retire_t       o_retire
);

    logic [`LC4_WORD_W-1:0] pc_q;
    lc4_pkg::stage_t        f_rec;
    lc4_pkg::stage_t        d_q;
    lc4_pkg::stage_t        x_in;
    lc4_pkg::stage_t        x_q;
    lc4_pkg::decode_t       d_dec;
    logic [`LC4_WORD_W-1:0] rs_rf;
    logic [`LC4_WORD_W-1:0] rt_rf;
    logic [`LC4_WORD_W-1:0] rs_q;
    logic [`LC4_WORD_W-1:0] rt_q;
    lc4_pkg::wb_t           m_wb;
    lc4_pkg::wb_t           w_wb;
    logic [`LC4_WORD_W-1:0] x_result;
    logic [`LC4_WORD_W-1:0] x_target;
    logic                   x_redirect;
    logic                   flush_q;

    // only insn, pc and stall of the fetch record mean anything before decode
    always_comb begin
        f_rec          = '0;
        f_rec.dec.insn = i_cur_insn;
        f_rec.pc       = pc_q;
        f_rec.stall    = lc4_pkg::STALL_NONE;
    end

    // D record with its decoded control filled in
    always_comb begin
        x_in     = d_q;
        x_in.dec = d_dec;
    end

    // taken branch or jump in X squashes F and D
    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q    <= `LC4_RESET_PC;
            d_q     <= lc4_pkg::STAGE_BUBBLE;
            x_q     <= lc4_pkg::STAGE_BUBBLE;
            flush_q <= 1'b0;
        end else begin
            pc_q    <= x_redirect ? x_target : pc_q + 16'd1;
            d_q     <= x_redirect ? lc4_pkg::STAGE_BUBBLE : f_rec;
            x_q     <= x_redirect ? lc4_pkg::STAGE_BUBBLE : x_in;
            flush_q <= x_redirect;
        end
    end

    // register operands into X
    always_ff @(posedge gwe) begin
        rs_q <= rs_rf;
        rt_q <= rt_rf;
    end

    assign o_cur_pc = pc_q;

    lc4_decode u_decode (
        .i_insn (d_q.dec.insn),
        .o_dec  (d_dec)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_rs_sel  (d_dec.rs_sel),
        .i_rt_sel  (d_dec.rt_sel),
        .i_wb      (w_wb),
        .o_rs_data (rs_rf),
        .o_rt_data (rt_rf)
    );

    lc4_execute u_execute (
        .gwe        (gwe),
        .i_arst_n   (i_arst_n),
        .i_x        (x_q),
        .i_rs_data  (rs_q),
        .i_rt_data  (rt_q),
        .i_m_wb     (m_wb),
        .i_w_wb     (w_wb),
        .o_result   (x_result),
        .o_redirect (x_redirect),
        .o_target   (x_target)
    );

    lc4_result u_result (
        .gwe       (gwe),
        .i_arst_n  (i_arst_n),
        .i_x       (x_q),
        .i_result  (x_result),
        .i_flush_x (flush_q),
        .o_m_wb    (m_wb),
        .o_w_wb    (w_wb),
        .o_retire  (o_retire)
    );

endmodule

/* bench/lc4_checker.sv */
/*
 * retire-record and fetch-pc checker for the LC4 core testbench
 */
`timescale 1ns/1ps
`include "lc4_defines.svh"

module lc4_checker (
    input  logic                   gwe,
    input  logic                   i_arst_n,
    input  logic [`LC4_WORD_W-1:0] i_cur_pc,
    input  lc4_pkg::retire_t       i_retire,
    output bit                     o_done,
    output int                     o_val_errs,
    output int                     o_seq_errs,
    output int                     o_retired
);

    lc4_pkg::retire_t exp_q[$];
    int               bubbles;
    bit               pc_checked;

    // filled by the testbench top while it parses the trace
    task automatic add_expected(input lc4_pkg::retire_t rec);
        exp_q.push_back(rec);
    endtask

    task automatic check_field(input string name, input logic [15:0] exp_v,
                               input logic [15:0] act_v);
        if (exp_v !== act_v) begin
            $display("Error t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
            o_val_errs++;
        end
    endtask

    task automatic compare_record(input lc4_pkg::retire_t exp_r);
        int want;
        // 4 reset bubbles before the first insn, 2 after a taken branch or jump
        if (o_retired == 0) begin
            want = 4;
        end else if (exp_r.pc == exp_q[o_retired-1].pc + 16'd1) begin
            want = 0;
        end else begin
            want = 2;
        end
        if (bubbles != want) begin
            $display("at %0t: %0d bubble records before pc %h, %0d expected",
                     $time, bubbles, exp_r.pc, want);
            o_seq_errs++;
        end
        check_field("retire.pc", exp_r.pc, i_retire.pc);
        check_field("retire.insn", exp_r.insn, i_retire.insn);
        check_field("retire.reg_we", 16'(exp_r.reg_we), 16'(i_retire.reg_we));
        // wsel and data only mean something for a register write
        if (exp_r.reg_we) begin
            check_field("retire.wsel", 16'(exp_r.wsel), 16'(i_retire.wsel));
            check_field("retire.data", exp_r.data, i_retire.data);
        end
        check_field("retire.nzp_we", 16'(exp_r.nzp_we), 16'(i_retire.nzp_we));
        if (exp_r.nzp_we) begin
            check_field("retire.nzp", 16'(exp_r.nzp), 16'(i_retire.nzp));
        end
    endtask

    // sampled on the falling edge where the retire record is stable
    always @(negedge gwe) begin
        if (!i_arst_n) begin
            bubbles    = 0;
            pc_checked = 1'b0;
        end else if (!o_done) begin
            if (!pc_checked) begin
                check_field("o_cur_pc", `LC4_RESET_PC, i_cur_pc);
                pc_checked = 1'b1;
            end
            if (i_retire.stall != lc4_pkg::STALL_NONE) begin
                // a bubble must be a branch stall with no side effects
                check_field("retire.stall", 16'(lc4_pkg::STALL_BRANCH), 16'(i_retire.stall));
                check_field("retire.reg_we", 16'd0, 16'(i_retire.reg_we));
                check_field("retire.nzp_we", 16'd0, 16'(i_retire.nzp_we));
                bubbles++;
            end else if (o_retired >= exp_q.size()) begin
                $display("at %0t: unexpected record retired from pc %h", $time, i_retire.pc);
                o_seq_errs++;
            end else begin
                compare_record(exp_q[o_retired]);
                o_retired++;
                bubbles = 0;
                o_done  = (o_retired == exp_q.size());
            end
        end
    end

endmodule

/* bench/tb_lc4.sv */
/*
 * LC4 core testbench top with clock, reset, trace loader, instruction memory,
 * run limit and final verdict
 */
`timescale 1ns/1ps
`include "lc4_defines.svh"

module tb_lc4;

    logic                   gwe;
    logic                   arst_n;
    logic [`LC4_WORD_W-1:0] cur_insn;
    logic [`LC4_WORD_W-1:0] cur_pc;
    lc4_pkg::retire_t       retire;
    // sparse program memory keyed by the full fetch address
    logic [`LC4_WORD_W-1:0] imem [logic [`LC4_WORD_W-1:0]];
    bit                     done;
    int                     val_errs;
    int                     seq_errs;
    int                     retired;
    int                     exp_n;
    int                     cycles;
    bit                     trace_ok;

    lc4_core i_dut (
        .gwe        (gwe),
        .i_arst_n   (arst_n),
        .i_cur_insn (cur_insn),
        .o_cur_pc   (cur_pc),
        .o_retire   (retire)
    );

    lc4_checker i_chk (
        .gwe        (gwe),
        .i_arst_n   (arst_n),
        .i_cur_pc   (cur_pc),
        .i_retire   (retire),
        .o_done     (done),
        .o_val_errs (val_errs),
        .o_seq_errs (seq_errs),
        .o_retired  (retired)
    );

    always #5 gwe = ~gwe;

    // unloaded addresses read as 0x0000 which is a never-taken BR
    function automatic logic [15:0] fetch_word(input logic [15:0] pc);
        if (imem.exists(pc)) begin
            return imem[pc];
        end
        return 16'h0000;
    endfunction

    // fetch word and cycle count change 1 ns after each rising edge
    always @(posedge gwe) begin
        #1;
        cur_insn = fetch_word(cur_pc);
        cycles++;
    end

    // I lines load program words, R lines go to the checker in order
    task automatic load_trace(output bit ok);
        int fd;
        int a_v, b_v;
        int pc_v, insn_v, wsel_v, we_v, data_v, nzpwe_v, nzp_v;
        string line;
        lc4_pkg::retire_t rec;
        fd = $fopen("bench/lc4_trace.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "I %h %h", a_v, b_v) == 2) begin
                    imem[a_v[15:0]] = b_v[15:0];
                end else if ($sscanf(line, "R %h %h %h %h %h %h %h", pc_v, insn_v, wsel_v,
                                     we_v, data_v, nzpwe_v, nzp_v) == 7) begin
                    rec = '{pc: pc_v[15:0], insn: insn_v[15:0], stall: lc4_pkg::STALL_NONE,
                            reg_we: we_v[0], wsel: wsel_v[2:0], data: data_v[15:0],
                            nzp_we: nzpwe_v[0], nzp: nzp_v[2:0]};
                    i_chk.add_expected(rec);
                    exp_n++;
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        gwe      = 1'b0;
        arst_n   = 1'b0;
        cur_insn = '0;
        cycles   = 0;
        exp_n    = 0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("trace file bench/lc4_trace.txt could not be opened");
        end else if (exp_n == 0) begin
            $display("trace file holds no expected retire records");
        end else begin
            repeat (3) @(posedge gwe);
            #1;
            arst_n = 1'b1;
            // limit scales with the number of expected records
            while (!done && cycles < 4 * exp_n + 30) begin
                @(posedge gwe);
            end
            if (!done) begin
                $display("timeout after %0d cycles, only %0d of %0d records retired",
                         cycles, retired, exp_n);
            end
        end
        $display("value errors %0d, sequence errors %0d, records %0d of %0d",
                 val_errs, seq_errs, retired, exp_n);
        if (trace_ok && done && val_errs == 0 && seq_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+hw
hw/lc4_pkg.sv
hw/lc4_decode.sv
hw/lc4_regfile.sv
hw/lc4_execute.sv
hw/lc4_result.sv
hw/lc4_core.sv
bench/lc4_checker.sv
bench/tb_lc4.sv

/* run_sim.sh */
#!/bin/sh
# build the LC4 core testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_lc4 -o Vtb_lc4
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_lc4 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* bench/lc4_trace.txt */
# I addr insn : program word at a fetch address (hex)
# R pc insn wsel we data nzp_we nzp : expected retire record, in retire order (hex)
I 8200 9205
I 8201 95FD
I 8202 1642
I 8203 18D2
I 8204 5B1A
I 8205 5D43
I 8206 5F94
I 8207 13C6
I 8208 5448
I 8209 16A7
I 820A 58FF
I 820B 1B13
I 820C 0402
I 820D 9C01
I 820E 9C02
I 820F 0805
I 8210 9E34
I 8211 DFAB
I 8212 C803
I 8213 9209
I 8214 9209
I 8215 9209
I 8216 13E0
I 8217 0801
I 8218 9403
I 8219 1441
R 8200 9205 1 1 0005 1 1
R 8201 95FD 2 1 FFFD 1 4
R 8202 1642 3 1 0002 1 1
R 8203 18D2 4 1 0005 1 1
R 8204 5B1A 5 1 FFF8 1 4
R 8205 5D43 6 1 0000 1 2
R 8206 5F94 7 1 0005 1 1
R 8207 13C6 1 1 0005 1 1
R 8208 5448 2 1 FFFA 1 4
R 8209 16A7 3 1 0001 1 1
R 820A 58FF 4 1 0001 1 1
R 820B 1B13 5 1 0000 1 2
R 820C 0402 0 0 0000 0 0
R 820F 0805 0 0 0000 0 0
R 8210 9E34 7 1 0034 1 1
R 8211 DFAB 7 1 AB34 1 4
R 8212 C803 0 0 0000 0 0
R 8216 13E0 1 1 AB34 1 4
R 8217 0801 0 0 0000 0 0
R 8219 1441 2 1 5668 1 1
